/* testbench/serial_stimulus.txt */
# Columns: instruction word, expected o_result.rd, expected o_result.value (all hex)
# Lines starting with # are skipped, text after the third column is ignored
12300093 01 00000123  # ADDI x1, x0, 0x123
0000e093 01 00000123  # ORI  x1, x1, 0
fff00113 02 ffffffff  # ADDI x2, x0, -1
00016113 02 ffffffff  # ORI  x2, x2, 0
7ff00193 03 000007ff  # ADDI x3, x0, 0x7ff
0001e193 03 000007ff  # ORI  x3, x3, 0
80000213 04 fffff800  # ADDI x4, x0, -2048
00026213 04 fffff800  # ORI  x4, x4, 0
00100293 05 00000001  # ADDI x5, x0, 1
0002e293 05 00000001  # ORI  x5, x5, 0
00510333 06 00000000  # ADD  x6, x2, x5    carry through all 32 bits
403283b3 07 fffff802  # SUB  x7, x5, x3    negative result
40118433 08 000006dc  # SUB  x8, x3, x1
003204b3 09 ffffffff  # ADD  x9, x4, x3
00408533 0a fffff923  # ADD  x10, x1, x4
003575b3 0b 00000123  # AND  x11, x10, x3
0040e633 0c fffff923  # OR   x12, x1, x4
002546b3 0d 000006dc  # XOR  x13, x10, x2
55517713 0e 00000555  # ANDI x14, x2, 0x555
f000e793 0f ffffff23  # ORI  x15, x1, -256
0f01c813 10 0000070f  # XORI x16, x3, 0x0f0
fff24893 11 000007ff  # XORI x17, x4, -1
ff057913 12 fffff920  # ANDI x18, x10, -16
005282b3 05 00000002  # ADD  x5, x5, x5
005282b3 05 00000004  # ADD  x5, x5, x5
0002e993 13 00000004  # ORI  x19, x5, 0
10008093 01 00000223  # ADDI x1, x1, 0x100
00208033 00 00000222  # ADD  x0, x1, x2    result reported, not stored
00000313 06 00000000  # ADDI x6, x0, 0
00100a33 14 00000223  # ADD  x20, x0, x1
32100a93 15 00000321  # ADDI x21, x0, 0x321
00002ab3 15 00000000  # SLT  x21, x0, x0   unsupported, no write
000aeb13 16 00000321  # ORI  x22, x21, 0
00003a93 15 00000000  # SLTIU x21, x0, 0   unsupported, no write
000aeb93 17 00000321  # ORI  x23, x21, 0

/* all.f */
rtl/serial_pkg.sv
rtl/bit_regfile.sv
rtl/instr_decoder.sv
rtl/bit_sequencer.sv
rtl/serial_alu.sv
rtl/serial_core.sv
testbench/tb_serial_core.sv

/* Bender.yml */
package:
  name: serial_core

sources:
  - rtl/serial_pkg.sv
  - rtl/bit_regfile.sv
  - rtl/instr_decoder.sv
  - rtl/bit_sequencer.sv
  - rtl/serial_alu.sv
  - rtl/serial_core.sv
  - target: simulation
    files:
      - testbench/tb_serial_core.sv

/* testbench/tb_serial_core.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_serial_core;

   localparam int    CLK_HALF  = 20;    // 40 ns period
   localparam int    RST_CYC   = 4;
   localparam int    DONE_WAIT = 100;   // Cycles allowed per command
   localparam int    MAX_CMDS  = 512;   // Guard against a runaway file
   localparam string STIM_FILE = "testbench/serial_stimulus.txt";

   logic                clk;
   logic                rst;
   logic                cmd_valid;
   serial_pkg::instr_u  cmd_instr;
   logic                busy;
   logic                done;
   serial_pkg::result_t result;

   int errors;   // Failed checks and timeouts
   int checks;
   int ncmds;

   serial_core i_serial_core (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_cmd_valid (cmd_valid),
      .i_cmd_instr (cmd_instr),
      .o_busy      (busy),
      .o_done      (done),
      .o_result    (result)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #CLK_HALF clk = ~clk;
      end
   end

   // Both fields of a finished result
   task automatic check_result(
      input serial_pkg::result_t act,
      input serial_pkg::result_t exp,
      input int                  idx
   );
      checks++;
      if (act.rd !== exp.rd) begin
         errors++;
         $display("ERR o_result.rd cmd %0d: got %h, expected %h", idx, act.rd, exp.rd);
      end
      if (act.value !== exp.value) begin
         errors++;
         $display("ERR o_result.value cmd %0d: got %h, expected %h", idx, act.value, exp.value);
      end
   endtask

   // Single-bit status outputs
   task automatic check_flag(
      input string name,
      input logic  act,
      input logic  exp,
      input int    idx
   );
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s cmd %0d: got %h, expected %h", name, idx, act, exp);
      end
   endtask

   // One strobe, then wait for the completion pulse
   task automatic run_command(
      input logic [31:0]         instr,
      input serial_pkg::result_t exp,
      input int                  idx
   );
      int   cyc;
      logic seen;
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd_instr <= instr;
      @(posedge clk);            // Accepted on this edge
      cmd_valid <= 1'b0;
      @(negedge clk);
      check_flag("o_busy", busy, 1'b1, idx);  // Busy from the cycle after acceptance
      seen = 1'b0;
      cyc  = 0;
      while (!seen && cyc < DONE_WAIT) begin
         @(negedge clk);         // Outputs settled mid-cycle
         seen = done;
         cyc++;
      end
      if (!seen) begin
         errors++;
         $display("Command %0d (instruction %h) gave no o_done within %0d cycles",
                  idx, instr, DONE_WAIT);
      end else begin
         check_flag("o_busy", busy, 1'b0, idx);   // Idle in the done cycle
         check_result(result, exp, idx);
         @(negedge clk);
         check_flag("o_done", done, 1'b0, idx);   // Single-cycle pulse
         check_result(result, exp, idx);          // Value held after the pulse
      end
   endtask

   initial begin
      int                  fd;
      int                  nchar;
      int                  nf;
      logic [8*160-1:0]    line;
      logic [31:0]         word;
      logic [31:0]         erd;
      logic [31:0]         evalue;
      serial_pkg::result_t exp;
      errors    = 0;
      checks    = 0;
      ncmds     = 0;
      rst       = 1'b1;
      cmd_valid = 1'b0;
      cmd_instr = '0;
      repeat (RST_CYC) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_flag("o_busy", busy, 1'b0, -1);  // Quiet after reset
      check_flag("o_done", done, 1'b0, -1);
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open the stimulus file %s", STIM_FILE);
      end else begin
         while (!$feof(fd) && ncmds < MAX_CMDS) begin
            nchar = $fgets(line, fd);
            if (nchar > 0) begin
               nf = $sscanf(line, "%h %h %h", word, erd, evalue);
               if (nf == 3) begin
                  exp.rd    = erd[serial_pkg::REG_AW-1:0];
                  exp.value = evalue;
                  run_command(word, exp, ncmds);
                  ncmds++;
               end else if (nf > 0) begin
                  errors++;   // Partial line, likely a typo in the file
                  $display("Stimulus line after command %0d has %0d of 3 fields",
                           ncmds, nf);
               end
            end
         end
         $fclose(fd);
         if (ncmds == 0) begin
            errors++;
            $display("The stimulus file held no commands");
         end
      end
      repeat (2) @(posedge clk);
      $display("Commands: %0d, checks: %0d, errors: %0d", ncmds, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/serial_core.sv */
`default_nettype none
`timescale 1ns/100ps

module serial_core (
   input  wire logic               i_clk,
   input  wire logic               i_rst,
   input  wire logic               i_cmd_valid,  // Single-cycle strobe
   input  wire serial_pkg::instr_u i_cmd_instr,
   output logic                    o_busy,
   output logic                    o_done,
   output serial_pkg::result_t     o_result
);

   serial_pkg::op_desc_t          desc;
   serial_pkg::result_t           result_q;    // Held between completions
   logic                          accept;
   logic                          rs_en;
   logic                          rd_en;       // Write phase from sequencer
   logic                          first;
   logic                          seq_done;
   logic                          rs1_bit;
   logic                          rs2_bit;
   logic                          rd_bit;
   logic [serial_pkg::BIT_AW-1:0] rbit;
   logic [serial_pkg::BIT_AW-1:0] wbit;
   logic [serial_pkg::XLEN-1:0]   alu_word;

   instr_decoder i_instr_decoder (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_accept (accept),
      .i_instr  (i_cmd_instr),
      .o_desc   (desc)
   );

   bit_sequencer i_bit_sequencer (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cmd_valid (i_cmd_valid),
      .i_write_en  (desc.write_en),
      .o_accept    (accept),
      .o_rs_en     (rs_en),
      .o_rbit      (rbit),
      .o_rd_en     (rd_en),
      .o_wbit      (wbit),
      .o_first     (first),
      .o_busy      (o_busy),
      .o_done      (seq_done)
   );

   // ALU still runs for NOPs and x0, only the write is suppressed
   bit_regfile i_bit_regfile (
      .i_clk      (i_clk),
      .i_rd_en    (rd_en & desc.write_en),
      .i_wbit     (wbit),
      .i_rd_addr  (desc.rd),
      .i_rd       (rd_bit),
      .i_rs_en    (rs_en),
      .i_rbit     (rbit),
      .i_rs1_addr (desc.rs1),
      .i_rs2_addr (desc.rs2),
      .o_rs1      (rs1_bit),
      .o_rs2      (rs2_bit)
   );

   serial_alu i_serial_alu (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_desc   (desc),
      .i_accept (accept),
      .i_valid  (rd_en),
      .i_first  (first),
      .i_rs1    (rs1_bit),
      .i_rs2    (rs2_bit),
      .o_rd     (rd_bit),
      .o_word   (alu_word)
   );

   always_ff @(posedge i_clk) begin
      if (seq_done) begin
         result_q <= '{rd: desc.rd, value: alu_word};
      end
   end

   // ALU word is complete in the done cycle, pass it straight through
   always_comb begin
      if (seq_done) begin
         o_result = '{rd: desc.rd, value: alu_word};
      end else begin
         o_result = result_q;
      end
   end

   assign o_done = seq_done;

endmodule

`default_nettype wire

/* rtl/serial_alu.sv */
`default_nettype none
`timescale 1ns/100ps

module serial_alu (
   input  wire logic                     i_clk,
   input  wire logic                     i_rst,
   input  wire serial_pkg::op_desc_t     i_desc,
   input  wire logic                     i_accept,
   input  wire logic                     i_valid,  // Write phase, one bit per cycle
   input  wire logic                     i_first,  // Bit 0 cycle
   input  wire logic                     i_rs1,
   input  wire logic                     i_rs2,
   output logic                          o_rd,
   output logic [serial_pkg::XLEN-1:0]   o_word
);

   logic                        load_q;   // Descriptor valid, load imm
   logic [serial_pkg::XLEN-1:0] imm_sr;   // LSB is the current imm bit
   logic                        carry_q;
   logic                        is_sub;
   logic                        op_b;     // Raw second operand
   logic                        b_eff;    // Inverted for SUB
   logic                        cin;
   logic                        sum;
   logic                        cout;

   // Descriptor lands one edge after accept
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         load_q <= 1'b0;
      end else begin
         load_q <= i_accept;
      end
   end

   always_ff @(posedge i_clk) begin
      if (load_q) begin
         imm_sr <= i_desc.imm;
      end else if (i_valid) begin
         imm_sr <= imm_sr >> 1;  // Next bit to LSB
      end
   end

   assign is_sub = i_desc.alu_op == serial_pkg::ALU_SUB;
   assign op_b   = i_desc.use_imm ? imm_sr[0] : i_rs2;
   assign b_eff  = op_b ^ is_sub;
   assign cin    = i_first ? is_sub : carry_q;  // +1 of two's complement on bit 0

   // Full adder on one bit
   assign sum  = i_rs1 ^ b_eff ^ cin;
   assign cout = (i_rs1 & b_eff) | (cin & (i_rs1 ^ b_eff));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
      end else if (i_valid) begin
         carry_q <= cout;
      end
   end

   always_comb begin
      case (i_desc.alu_op)
         serial_pkg::ALU_AND: o_rd = i_rs1 & op_b;
         serial_pkg::ALU_OR:  o_rd = i_rs1 | op_b;
         serial_pkg::ALU_XOR: o_rd = i_rs1 ^ op_b;
         default:             o_rd = sum;  // ADD and SUB
      endcase
   end

   // Shift in from the top, bit 0 reaches the LSB after 32 cycles
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_word <= {o_rd, o_word[serial_pkg::XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

/* rtl/bit_sequencer.sv */
`default_nettype none
`timescale 1ns/100ps

// Phase p: read bit p (0..31), write bit p-1 (1..32)
module bit_sequencer (
   input  wire logic                    i_clk,
   input  wire logic                    i_rst,
   input  wire logic                    i_cmd_valid,
   input  wire logic                    i_write_en,  // Descriptor writeback flag
   output logic                         o_accept,
   output logic                         o_rs_en,
   output logic [serial_pkg::BIT_AW-1:0] o_rbit,
   output logic                         o_rd_en,
   output logic [serial_pkg::BIT_AW-1:0] o_wbit,
   output logic                         o_first,
   output logic                         o_busy,
   output logic                         o_done
);

   localparam logic [serial_pkg::BIT_AW:0] LAST = (serial_pkg::BIT_AW+1)'(serial_pkg::XLEN);

   logic [serial_pkg::BIT_AW:0] phase_q;  // One extra bit for the trailing write
   logic                        busy_q;
   logic                        done_q;

   // Idle and not reporting, so a strobe in the done cycle is dropped
   assign o_accept = i_cmd_valid & ~busy_q & ~done_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         phase_q <= '0;
         busy_q  <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;  // Single-cycle pulse
         if (o_accept) begin
            phase_q <= '0;
            busy_q  <= 1'b1;
         end else if (busy_q) begin
            phase_q <= phase_q + 1'b1;
            if (phase_q == LAST) begin  // Final write cycle
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end
      end
   end

   assign o_rs_en = busy_q & ~phase_q[serial_pkg::BIT_AW];   // Phases 0..31
   assign o_rbit  = phase_q[serial_pkg::BIT_AW-1:0];
   assign o_rd_en = busy_q & (phase_q != '0);               // Phases 1..32
   assign o_wbit  = o_rbit - 1'b1;                         // Lags read by one, wraps to 31
   assign o_first = busy_q & (phase_q == 1);               // ALU sees bit 0
   assign o_busy  = busy_q;
   assign o_done  = done_q;

   // Each written bit was read one cycle earlier
   a_write_in_busy : assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_rd_en |-> o_busy && $past(o_rs_en)
   );

   a_done_no_accept : assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_done |-> !o_accept
   );

   // Decoder must not change the descriptor under a running stream
   a_write_en_stable : assert property (
      @(posedge i_clk) disable iff (i_rst)
      busy_q && $past(busy_q) |-> $stable(i_write_en)
   );

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
`default_nettype none
`timescale 1ns/100ps

module instr_decoder (
   input  wire logic               i_clk,
   input  wire logic               i_rst,
   input  wire logic               i_accept,  // Command taken this edge
   input  wire serial_pkg::instr_u i_instr,
   output serial_pkg::op_desc_t    o_desc
);

   serial_pkg::op_desc_t desc_d;
   logic                 legal;  // Supported encoding

   always_comb begin
      desc_d         = '0;
      legal          = 1'b0;
      desc_d.rd      = i_instr.r.rd;
      desc_d.rs1     = i_instr.r.rs1;
      desc_d.imm     = {{(serial_pkg::XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
      if (i_instr.r.opcode == serial_pkg::OPC_OP) begin
         desc_d.rs2 = i_instr.r.rs2;  // R view with funct7 and rs2 on top
         case (i_instr.r.funct3)
            serial_pkg::F3_ADD: begin
               legal = (i_instr.r.funct7 == serial_pkg::F7_BASE) ||
                       (i_instr.r.funct7 == serial_pkg::F7_ALT);
               if (i_instr.r.funct7[5]) begin
                  desc_d.alu_op = serial_pkg::ALU_SUB;
               end else begin
                  desc_d.alu_op = serial_pkg::ALU_ADD;
               end
            end
            serial_pkg::F3_XOR: begin
               legal         = i_instr.r.funct7 == serial_pkg::F7_BASE;
               desc_d.alu_op = serial_pkg::ALU_XOR;
            end
            serial_pkg::F3_OR: begin
               legal         = i_instr.r.funct7 == serial_pkg::F7_BASE;
               desc_d.alu_op = serial_pkg::ALU_OR;
            end
            serial_pkg::F3_AND: begin
               legal         = i_instr.r.funct7 == serial_pkg::F7_BASE;
               desc_d.alu_op = serial_pkg::ALU_AND;
            end
            default: legal = 1'b0;  // SLT, shifts etc. become NOP
         endcase
      end else if (i_instr.i.opcode == serial_pkg::OPC_OPIMM) begin
         desc_d.use_imm = 1'b1;  // I view with the immediate on top
         legal          = 1'b1;
         case (i_instr.i.funct3)
            serial_pkg::F3_ADD: desc_d.alu_op = serial_pkg::ALU_ADD;
            serial_pkg::F3_XOR: desc_d.alu_op = serial_pkg::ALU_XOR;
            serial_pkg::F3_OR:  desc_d.alu_op = serial_pkg::ALU_OR;
            serial_pkg::F3_AND: desc_d.alu_op = serial_pkg::ALU_AND;
            default:            legal = 1'b0;
         endcase
      end
      desc_d.write_en = legal && (desc_d.rd != '0);  // x0 and NOPs skip writeback
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_desc <= '0;
      end else if (i_accept) begin
         o_desc <= desc_d;  // Held for the whole bit stream
      end
   end

   a_alu_op_legal : assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_desc.alu_op inside {serial_pkg::ALU_ADD, serial_pkg::ALU_SUB, serial_pkg::ALU_AND,
                            serial_pkg::ALU_OR, serial_pkg::ALU_XOR}
   );

endmodule

`default_nettype wire

/* rtl/bit_regfile.sv */
`default_nettype none
`timescale 1ns/100ps

// Transposed storage: word k holds bit k of every register,
// column r of each word belongs to register x<r>
module bit_regfile (
   input  wire logic                          i_clk,
   input  wire logic                          i_rd_en,     // Write strobe
   input  wire logic [serial_pkg::BIT_AW-1:0] i_wbit,      // Word to write
   input  wire logic [serial_pkg::REG_AW-1:0] i_rd_addr,   // Column to write
   input  wire logic                          i_rd,        // Write data bit
   input  wire logic                          i_rs_en,     // Read strobe
   input  wire logic [serial_pkg::BIT_AW-1:0] i_rbit,      // Word to read
   input  wire logic [serial_pkg::REG_AW-1:0] i_rs1_addr,
   input  wire logic [serial_pkg::REG_AW-1:0] i_rs2_addr,
   output logic                               o_rs1,
   output logic                               o_rs2
);

   logic [serial_pkg::NREG-1:0] mem [serial_pkg::XLEN];  // 32 words x 32 columns
   logic [serial_pkg::NREG-1:0] wmask;                   // One-hot column select
   logic [serial_pkg::NREG-1:0] rword_q;                 // Registered read word
   logic [serial_pkg::NREG-1:0] rword;

   // One-hot write mask, x0 column never enabled
   always_comb begin
      wmask            = '0;
      wmask[i_rd_addr] = 1'b1;
      wmask[0]         = 1'b0;
   end

   // Masked write, only the selected column of the word changes
   always_ff @(posedge i_clk) begin
      if (i_rd_en) begin
         for (int c = 0; c < serial_pkg::NREG; c++) begin
            if (wmask[c]) begin
               mem[i_wbit][c] <= i_rd;
            end
         end
      end
   end

   // One-cycle read, word lands the cycle after the strobe
   always_ff @(posedge i_clk) begin
      if (i_rs_en) begin
         rword_q <= mem[i_rbit];
      end
   end

   // Column 0 is never written, so force it here
   assign rword = {rword_q[serial_pkg::NREG-1:1], 1'b0};

   assign o_rs1 = rword[i_rs1_addr];  // Column select for each source
   assign o_rs2 = rword[i_rs2_addr];

   // Data bit from the ALU must be resolved when written
   a_wdata_known : assert property (
      @(posedge i_clk) i_rd_en |-> !$isunknown(i_rd)
   );

endmodule

`default_nettype wire

/* rtl/serial_pkg.sv */
`default_nettype none

package serial_pkg;

   localparam int XLEN   = 32;           // Register width
   localparam int REG_AW = 5;            // Register address bits
   localparam int BIT_AW = 5;            // Bit index, one memory word per bit
   localparam int NREG   = 1 << REG_AW;  // One memory column per register

   // Major opcodes
   localparam logic [6:0] OPC_OP    = 7'b0110011;  // Register-register
   localparam logic [6:0] OPC_OPIMM = 7'b0010011;  // Register-immediate

   // funct3 codes, shared by both formats
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;  // Selects SUB

   typedef struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0]       imm12;  // Sign bit at the top
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
   } i_fmt_t;

   // Low 20 bits line up, top 12 are funct7/rs2 or the immediate
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   typedef struct packed {
      alu_op_e           alu_op;
      logic              use_imm;   // Operand b from imm, not rs2
      logic              write_en;  // Clear for NOP or rd of x0
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic [XLEN-1:0]   imm;       // Already sign extended
   } op_desc_t;

   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   value;
   } result_t;

endpackage

`default_nettype wire
